//--- Bender.yml
package:
  name: front_panel

sources:
  - verilog/board_pkg.sv
  - verilog/panel_pkg.sv
  - verilog/byte_link_if.sv
  - verilog/uart_rx.sv
  - verilog/key_debounce.sv
  - verilog/panel_ctrl.sv
  - verilog/seg_scan.sv
  - verilog/panel_top.sv
  - target: test
    files:
      - dv/panel_chk.sv
      - dv/panel_tb.sv

//--- all.f
verilog/board_pkg.sv
verilog/panel_pkg.sv
verilog/byte_link_if.sv
verilog/uart_rx.sv
verilog/key_debounce.sv
verilog/panel_ctrl.sv
verilog/seg_scan.sv
verilog/panel_top.sv
dv/panel_chk.sv
dv/panel_tb.sv

//--- dv/panel_chk.sv
/*
 * concurrent checks on the uart to controller byte link and the digit select,
 * bound into the panel top where both are visible
 */
`timescale 1ns/1ps
`default_nettype none

module panel_chk (
	input wire       sys_clk,
	input wire       sys_rst_n,
	input wire       req,
	input wire       ack,
	input wire [7:0] data,
	input wire [7:0] seg_choice
);

	// failed assertions so far, read by the testbench at the end
	int unsigned fail_count = 0;

	// sink only answers an open request
	ack_needs_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(ack) |-> req)
		else begin
			$error("ack rose without req");
			fail_count++;
		end

	// no withdrawn request before it is answered
	req_holds: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		req && !ack |=> req)
		else begin
			$error("req dropped before ack");
			fail_count++;
		end

	data_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		req && $past(req) |-> $stable(data))
		else begin
			$error("link data moved while req was high");
			fail_count++;
		end

	// exactly one digit driven low
	select_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice))
		else begin
			$error("seg_choice is not one-hot low");
			fail_count++;
		end

endmodule

bind panel_top panel_chk i_panel_chk (
	.sys_clk    (sys_clk),
	.sys_rst_n  (sys_rst_n),
	.req        (i_link.req),
	.ack        (i_link.ack),
	.data       (i_link.data),
	.seg_choice (seg_choice)
);

`default_nettype wire

//--- dv/panel_tb.sv
/*
 * testbench for the front panel top: uart frames and key presses from a table,
 * the display is read back through the digit scan and compared with the table
 */
`timescale 1ns/1ps
`default_nettype none

module panel_tb;

	typedef enum logic [1:0] {UART_BYTE, UART_BAD_STOP, KEY_PRESS, KEY_BOUNCE} kind_e;

	// one stimulus step and the panel state expected after it
	typedef struct packed {
		kind_e       kind;
		logic [7:0]  value;
		logic [31:0] image;
		logic [7:0]  led;
		logic        beep;
	} entry_t;

	localparam int n_entries = 8;
	localparam int wait_limit = 1000;

	logic       sys_clk;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic       uart_line;
	wire  [7:0] led;
	wire  [7:0] seg_number;
	wire  [7:0] seg_choice;
	wire        bepeer;

	entry_t     stim [n_entries];
	// active low a..g, dp off, hex 0..f
	logic [7:0] seg_ref [16];
	int         seed;
	int         err_count;
	int         check_count;
	bit         timed_out;
	bit         entry_ok;

	panel_top i_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.uart_rx_port (uart_line),
		.led          (led),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.bepeer       (bepeer)
	);

	always #2 sys_clk = ~sys_clk;

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			err_count++;
			entry_ok = 0;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t: %s never happened", $time, what);
		timed_out = 1;
		entry_ok = 0;
	endtask

	// msb set when the pattern is one of the sixteen hex digits
	function automatic logic [4:0] seg_to_nibble(input logic [7:0] pattern);
		for (int n = 0; n < 16; n++) begin
			if (seg_ref[n] === pattern) begin
				return {1'b1, n[3:0]};
			end
		end
		return 5'd0;
	endfunction

	task automatic wait_ack(input logic level);
		int n = 0;
		if (timed_out) return;
		while (i_dut.i_link.ack !== level && n < wait_limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (i_dut.i_link.ack !== level) report_timeout("byte link ack change");
	endtask

	task automatic wait_press(input int idx);
		int n = 0;
		if (timed_out) return;
		while (i_dut.key_press[idx] !== 1'b1 && n < wait_limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (i_dut.key_press[idx] !== 1'b1) report_timeout("debounced key press");
	endtask

	task automatic wait_release(input int idx);
		int n = 0;
		if (timed_out) return;
		while (i_dut.i_key_debounce.key_level[idx] !== 1'b0 && n < wait_limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (i_dut.i_key_debounce.key_level[idx] !== 1'b0) report_timeout("key release");
	endtask

	// start, eight data bits lsb first, stop; line held at stop until the link is idle
	task automatic send_frame(input logic [7:0] b, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			uart_line <= bits[i];
			if (i < 9) repeat (board_pkg::bit_cycles - 1) @(posedge sys_clk);
		end
		wait_ack(1'b1);
		wait_ack(1'b0);
		@(posedge sys_clk);
		uart_line <= 1'b1;
		repeat (board_pkg::bit_cycles) @(posedge sys_clk);
	endtask

	// tone must run inside the window and stop after it
	task automatic check_beep();
		int   toggles = 0;
		logic last;
		last = bepeer;
		repeat (board_pkg::beep_cycles) begin
			@(negedge sys_clk);
			if (bepeer !== last) toggles++;
			last = bepeer;
		end
		check_value("beep toggles seen", toggles >= board_pkg::beep_cycles
			/ (2 * board_pkg::tone_half), 1);
		repeat (8) @(negedge sys_clk);
		check_value("bepeer after beep window", bepeer, 0);
	endtask

	task automatic press_key(input int idx, input logic beep);
		@(posedge sys_clk);
		key_in[idx] <= 1'b0;
		wait_press(idx);
		if (beep && !timed_out) check_beep();
		@(posedge sys_clk);
		key_in[idx] <= 1'b1;
		wait_release(idx);
	endtask

	// random glitches, each shorter than the debounce time, must not register
	task automatic bounce_key(input int idx);
		int len;
		int pulses = 0;
		for (int g = 0; g < 4; g++) begin
			len = 1 + ($unsigned($random(seed)) % (board_pkg::debounce_cycles - 8));
			@(posedge sys_clk);
			key_in[idx] <= 1'b0;
			repeat (len) begin
				@(negedge sys_clk);
				if (i_dut.key_press[idx] === 1'b1) pulses++;
			end
			@(posedge sys_clk);
			key_in[idx] <= 1'b1;
			repeat (3) begin
				@(negedge sys_clk);
				if (i_dut.key_press[idx] === 1'b1) pulses++;
			end
		end
		check_value("press pulses during bounce", pulses, 0);
	endtask

	// walk the scan once, one nibble per selected digit
	task automatic read_image(output logic [31:0] image);
		int         n;
		logic [4:0] dec;
		logic [7:0] sel;
		image = '0;
		for (int d = 0; d < 8; d++) begin
			n = 0;
			sel = ~(8'd1 << d);
			@(negedge sys_clk);
			while (seg_choice !== sel && n < wait_limit) begin
				@(negedge sys_clk);
				n++;
			end
			if (seg_choice !== sel) begin
				report_timeout("digit select in the scan");
				return;
			end
			dec = seg_to_nibble(seg_number);
			check_value("segment pattern decodes", dec[4], 1);
			image[d*4 +: 4] = dec[3:0];
		end
	endtask

	initial begin
		logic [31:0] image;
		seed = 67002;
		err_count = 0;
		check_count = 0;
		timed_out = 0;
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		key_in = 4'hF;
		uart_line = 1'b1;
		seg_ref = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
			8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
		// scroll, digit write, bad stop, beep, bounced clear, scroll, digit write
		stim[0] = '{UART_BYTE, 8'h12, 32'h0000_0012, 8'h12, 1'b0};
		stim[1] = '{UART_BYTE, 8'h3A, 32'h0000_123A, 8'h3A, 1'b0};
		stim[2] = '{UART_BYTE, 8'hD5, 32'h0050_123A, 8'h3A, 1'b0};
		stim[3] = '{UART_BAD_STOP, 8'h77, 32'h0050_123A, 8'h3A, 1'b0};
		stim[4] = '{KEY_PRESS, 8'd1, 32'h0050_123A, 8'h3A, 1'b1};
		stim[5] = '{KEY_BOUNCE, 8'd0, 32'h0000_0000, 8'h3A, 1'b0};
		stim[6] = '{UART_BYTE, 8'h45, 32'h0000_0045, 8'h45, 1'b0};
		stim[7] = '{UART_BYTE, 8'h9F, 32'h0000_00F5, 8'h45, 1'b0};

		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		entry_ok = 1;
		read_image(image);
		check_value("image after reset", image, 32'h0);
		check_value("led after reset", led, 8'h0);
		$display("test reset: %s", entry_ok ? "ok" : "mismatch");

		for (int i = 0; i < n_entries && !timed_out; i++) begin
			entry_ok = 1;
			case (stim[i].kind)
				UART_BYTE: send_frame(stim[i].value, 1'b1);
				UART_BAD_STOP: send_frame(stim[i].value, 1'b0);
				KEY_PRESS: press_key(stim[i].value, stim[i].beep);
				KEY_BOUNCE: begin
					bounce_key(stim[i].value);
					press_key(stim[i].value, stim[i].beep);
				end
			endcase
			if (!timed_out) begin
				read_image(image);
				check_value("display image", image, stim[i].image);
				check_value("led", led, stim[i].led);
				check_value("bepeer idle", bepeer, 0);
			end
			$display("test %0d %s %h: %s", i, stim[i].kind.name(), stim[i].value,
				entry_ok ? "ok" : "mismatch");
		end

		$display("checks %0d, errors %0d, assertion failures %0d, timeout %0d",
			check_count, err_count, i_dut.i_panel_chk.fail_count, timed_out);
		if (err_count == 0 && i_dut.i_panel_chk.fail_count == 0 && !timed_out) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/board_pkg.sv
/*
 * board level timing constants and key assignments, kept at simulation scale
 * referenced by scoped name from the receiver, debouncer, controller and scan
 */
`default_nettype none

package board_pkg;

	// sys_clk cycles per uart bit
	localparam int unsigned bit_cycles = 16;

	// stable cycles before a key level is accepted
	localparam int unsigned debounce_cycles = 32;

	// cycles each display digit stays selected
	localparam int unsigned scan_cycles = 8;

	// buzzer on-time after a beep key press
	localparam int unsigned beep_cycles = 64;

	// half period of the buzzer square wave
	localparam int unsigned tone_half = 4;

	// key roles on the front panel
	localparam int unsigned key_clear = 0;
	localparam int unsigned key_beep = 1;

endpackage

`default_nettype wire

//--- verilog/byte_link_if.sv
/*
 * four-phase req/ack byte link from the uart receiver to the panel controller
 * source holds data and err from req rise until ack is seen
 */
`timescale 1ns/1ps
`default_nettype none

interface byte_link_if;

	logic       req;
	logic       ack;
	// received byte and its framing error flag
	logic [7:0] data;
	logic       err;

	// uart side
	modport source (output req, output data, output err, input ack);

	// controller side
	modport sink (input req, input data, input err, output ack);

endinterface

`default_nettype wire

//--- verilog/key_debounce.sv
/*
 * debouncer for the four active low panel keys
 * gives the accepted level (pressed = 1) and a one cycle press pulse
 */
`timescale 1ns/1ps
`default_nettype none

module key_debounce (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire  [3:0] key_in,
	output logic [3:0] key_level,
	output logic [3:0] key_press
);

	logic [3:0] key_meta;
	// synchronized, already inverted to pressed = 1
	logic [3:0] key_sync;
	logic [$clog2(board_pkg::debounce_cycles)-1:0] stab_cnt [4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta <= '0;
			key_sync <= '0;
		end else begin
			key_meta <= ~key_in;
			key_sync <= key_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_level <= '0;
			key_press <= '0;
			for (int k = 0; k < 4; k++) begin
				stab_cnt[k] <= '0;
			end
		end else begin
			for (int k = 0; k < 4; k++) begin
				key_press[k] <= 1'b0;
				if (key_sync[k] == key_level[k]) begin
					// bounced back, start over
					stab_cnt[k] <= '0;
				end else if (stab_cnt[k] == board_pkg::debounce_cycles - 1) begin
					// new level held long enough
					stab_cnt[k]  <= '0;
					key_level[k] <= key_sync[k];
					key_press[k] <= key_sync[k];
				end else begin
					stab_cnt[k] <= stab_cnt[k] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/panel_ctrl.sv
/*
 * panel controller: takes bytes off the link, keeps the eight digit image,
 * latches data bytes on the leds and times the buzzer from the beep key
 */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	byte_link_if.sink   link,
	input  wire  [3:0]  key_press,
	output logic [31:0] digits,
	output logic [7:0]  led,
	output logic        bepeer
);

	panel_pkg::rx_byte_u rx_byte;
	// first cycle of req, byte applied here
	logic take;
	logic beep_on;
	logic [$clog2(board_pkg::beep_cycles)-1:0] beep_cnt;
	logic [$clog2(board_pkg::tone_half)-1:0] tone_cnt;

	assign rx_byte = link.data;
	assign take = link.req && !link.ack;

	// four-phase sink side
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			link.ack <= 1'b0;
		end else if (take) begin
			link.ack <= 1'b1;
		end else if (link.ack && !link.req) begin
			link.ack <= 1'b0;
		end
	end

	// display image, clear key wins over a byte in the same cycle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			digits <= '0;
			led    <= '0;
		end else if (key_press[board_pkg::key_clear]) begin
			digits <= '0;
		end else if (take && !link.err) begin
			if (rx_byte.cmd.flag) begin
				// single digit write
				digits[rx_byte.cmd.idx*4 +: 4] <= rx_byte.cmd.value;
			end else begin
				// scroll left by two digits
				digits <= {digits[panel_pkg::digit_count*4-9:0], rx_byte.hex.hi, rx_byte.hex.lo};
				led    <= link.data;
			end
		end
	end

	// beep window and tone divider
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			beep_on  <= 1'b0;
			beep_cnt <= '0;
			tone_cnt <= '0;
			bepeer   <= 1'b0;
		end else if (key_press[board_pkg::key_beep]) begin
			// restart on every press
			beep_on  <= 1'b1;
			beep_cnt <= '0;
			tone_cnt <= '0;
			bepeer   <= 1'b0;
		end else if (beep_on) begin
			beep_cnt <= beep_cnt + 1'b1;
			if (beep_cnt == board_pkg::beep_cycles - 1) begin
				// window over, leave the buzzer quiet
				beep_on <= 1'b0;
				bepeer  <= 1'b0;
			end else if (tone_cnt == board_pkg::tone_half - 1) begin
				tone_cnt <= '0;
				bepeer   <= ~bepeer;
			end else begin
				tone_cnt <= tone_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/panel_pkg.sv
/*
 * display side definitions: the two decodings of a received byte,
 * the digit count of the display image and the hex segment table
 */
`default_nettype none

package panel_pkg;

	// top bit picks the view, 0 = two hex digits, 1 = digit write
	typedef union packed {
		struct packed {
			logic [3:0] hi;
			logic [3:0] lo;
		} hex;
		struct packed {
			logic       flag;
			logic [2:0] idx;
			logic [3:0] value;
		} cmd;
	} rx_byte_u;

	// eight hex digits, four bits each
	localparam int unsigned digit_count = 8;

	// active low, a..g in bits 0..6, dp in bit 7 held off
	localparam logic [7:0] seg_hex [16] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
	};

endpackage

`default_nettype wire

//--- verilog/panel_top.sv
/*
 * front panel board top: uart and keys in, controller in the middle,
 * seven segment scan, leds and buzzer out
 */
`timescale 1ns/1ps
`default_nettype none

module panel_top (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire  [3:0] key_in,
	input  wire        uart_rx_port,
	output wire  [7:0] led,
	output wire  [7:0] seg_number,
	output wire  [7:0] seg_choice,
	output wire        bepeer
);

	wire [3:0]  key_press;
	// eight nibbles, digit 0 in the low bits
	wire [31:0] digits;

	byte_link_if i_link ();

	uart_rx i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.link      (i_link.source)
	);

	// level output not needed on this board
	key_debounce i_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_level (),
		.key_press (key_press)
	);

	panel_ctrl i_panel_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.link      (i_link.sink),
		.key_press (key_press),
		.digits    (digits),
		.led       (led),
		.bepeer    (bepeer)
	);

	seg_scan i_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.digits     (digits),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

`default_nettype wire

//--- verilog/seg_scan.sv
/*
 * multiplexed seven segment driver for the eight digit hex image
 * digit 0 is rightmost; segment and select outputs are registered together
 */
`timescale 1ns/1ps
`default_nettype none

module seg_scan (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire  [31:0] digits,
	output logic [7:0]  seg_number,
	output logic [7:0]  seg_choice
);

	logic [$clog2(board_pkg::scan_cycles)-1:0] scan_cnt;
	logic [$clog2(panel_pkg::digit_count)-1:0] digit_idx;
	// nibble of the digit being scanned
	logic [3:0] nibble;

	assign nibble = digits[digit_idx*4 +: 4];

	// dwell counter, then step to the next digit
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt  <= '0;
			digit_idx <= '0;
		end else if (scan_cnt == board_pkg::scan_cycles - 1) begin
			scan_cnt  <= '0;
			// wraps 7 -> 0
			digit_idx <= digit_idx + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// same digit_idx feeds both, so they never disagree
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_number <= panel_pkg::seg_hex[0];
			seg_choice <= 8'hFE;
		end else begin
			seg_number <= panel_pkg::seg_hex[nibble];
			seg_choice <= ~(8'd1 << digit_idx);
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
/*
 * 8n1 uart receiver, samples at mid bit with bit_cycles clocks per bit
 * each frame is offered on the byte link and held through the handshake
 */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire         rx,
	byte_link_if.source link
);

	logic       rx_meta;
	logic       rx_sync;
	logic       rx_prev;
	// frame in progress
	logic       busy;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	logic [$clog2(board_pkg::bit_cycles)-1:0] bit_cnt;
	logic [7:0] shift;
	logic       sample;
	logic       stop_hit;

	// two flops against metastability, third for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// half a bit into the start bit, then full bits
	assign sample = busy && ((bit_idx == 4'd0) ? (bit_cnt == board_pkg::bit_cycles / 2 - 1)
		: (bit_cnt == board_pkg::bit_cycles - 1));
	assign stop_hit = sample && (bit_idx == 4'd9);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			bit_idx <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			// falling edge on an idle line
			if (rx_prev && !rx_sync) begin
				busy    <= 1'b1;
				bit_idx <= '0;
				bit_cnt <= '0;
			end
		end else if (sample) begin
			bit_cnt <= '0;
			if (bit_idx == 4'd0 && rx_sync) begin
				// glitch, not a real start bit
				busy <= 1'b0;
			end else if (bit_idx == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// lsb first
	always_ff @(posedge sys_clk) begin
		if (sample && bit_idx != 4'd0 && bit_idx != 4'd9) begin
			shift <= {rx_sync, shift[7:1]};
		end
	end

	// offer the frame, drop it if the last one is still in flight
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			link.req <= 1'b0;
		end else if (stop_hit && !link.req && !link.ack) begin
			link.req <= 1'b1;
		end else if (link.req && link.ack) begin
			link.req <= 1'b0;
		end
	end

	// payload only moves while the link is idle
	always_ff @(posedge sys_clk) begin
		if (stop_hit && !link.req && !link.ack) begin
			link.data <= shift;
			// stop bit low is a framing error
			link.err  <= !rx_sync;
		end
	end

endmodule

`default_nettype wire
